// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert -Wno-fatal
TOP       = agen_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+verilog
verilog/agen_pkg.sv
verilog/seg_desc_table.sv
verilog/string_ptr_tracker.sv
verilog/seg_limit_check.sv
verilog/agen_stage.sv
verilog/agen_top.sv
sim/clk_gen.sv
sim/agen_assertions.sv
sim/agen_tb.sv

// File: sim/agen_assertions.sv
`include "agen_consts.svh"

module agen_assertions
   import agen_pkg::*;
(
   input logic                        CLK,
   input logic                        rst,
   input logic                        psel,
   input logic                        penable,
   input logic                        pwrite,
   input logic [`AGEN_APB_ADDR_W-1:0] paddr,
   input logic [31:0]                 pwdata,
   input logic [31:0]                 prdata,
   input logic                        pready,
   input logic                        pslverr,
   input agen_uop_t                   uop_in,
   input logic                        stall,
   input agen_out_t                   out
);

   int unsigned err_count = 0;

   logic [31:0] base_sh  [`AGEN_NUM_SEGS];
   logic [31:0] limit_sh [`AGEN_NUM_SEGS];
   logic [31:0] src_sh;
   logic [31:0] dst_sh;
   logic        seen_valid;
   logic        in_map;
   logic        accept;
   logic [31:0] size_bytes;
   logic [31:0] exp_word;
   logic [31:0] exp_ofs;
   logic [31:0] exp_addr;
   logic [32:0] last_byte;
   logic        exp_exc;

   assign in_map = paddr < 8'(`AGEN_APB_MAP_BYTES);
   assign accept = uop_in.valid && !stall;
   assign size_bytes = (uop_in.size == 2'd0) ? 32'd1 :
                       (uop_in.size == 2'd1) ? 32'd2 : 32'd4;

   // Expected APB read word from the shadow table
   always_comb begin
      exp_word = 32'd0;
      if (paddr[2:0] == 3'd0)
         exp_word = base_sh[paddr[5:3]];
      else if (paddr[2:0] == 3'd4)
         exp_word = limit_sh[paddr[5:3]];
   end

   always_comb begin
      if (uop_in.kind == kind_mem)
         exp_ofs = uop_in.payload.mem.disp;
      else if (!uop_in.payload.str.steady)
         exp_ofs = {2'b00, uop_in.payload.str.ptr};
      else if (uop_in.payload.str.second)
         exp_ofs = uop_in.df ? dst_sh - size_bytes : dst_sh + size_bytes;
      else
         exp_ofs = uop_in.df ? src_sh - size_bytes : src_sh + size_bytes;
   end

   assign exp_addr  = base_sh[uop_in.seg] + exp_ofs;
   assign last_byte = {1'b0, exp_ofs} + {1'b0, size_bytes} - 33'd1;
   assign exp_exc   = last_byte > {1'b0, limit_sh[uop_in.seg]};

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `AGEN_NUM_SEGS; i++) begin
            base_sh[i]  <= '0;
            limit_sh[i] <= '0;
         end
         src_sh     <= '0;
         dst_sh     <= '0;
         seen_valid <= 1'b0;
      end else begin
         if (psel && penable && pwrite && in_map) begin
            if (paddr[2:0] == 3'd0)
               base_sh[paddr[5:3]] <= pwdata;
            if (paddr[2:0] == 3'd4)
               limit_sh[paddr[5:3]] <= pwdata;
         end
         if (accept)
            seen_valid <= 1'b1;
         // Each operand keeps its own pointer
         if (accept && uop_in.kind == kind_str) begin
            if (uop_in.payload.str.second)
               dst_sh <= exp_ofs;
            else
               src_sh <= exp_ofs;
         end
      end
   end

   a_pready: assert property (@(posedge CLK) pready)
      else begin
         err_count++;
         $error("[ERROR] %0t: pready low", $time);
      end

   a_pslverr: assert property (@(posedge CLK) disable iff (rst)
      psel && penable |-> pslverr == !in_map)
      else begin
         err_count++;
         $error("[ERROR] %0t: pslverr wrong for paddr %0h", $time, paddr);
      end

   a_readback: assert property (@(posedge CLK) disable iff (rst)
      psel && penable && !pwrite && in_map |-> prdata == exp_word)
      else begin
         err_count++;
         $error("[ERROR] %0t: prdata %0h, expected %0h", $time, prdata, exp_word);
      end

   a_valid: assert property (@(posedge CLK) disable iff (rst)
      accept |=> out.valid)
      else begin
         err_count++;
         $error("[ERROR] %0t: out.valid low after accepted uop", $time);
      end

   a_idle: assert property (@(posedge CLK) disable iff (rst)
      !stall && !uop_in.valid |=> !out.valid)
      else begin
         err_count++;
         $error("[ERROR] %0t: out.valid high after idle cycle", $time);
      end

   a_addr: assert property (@(posedge CLK) disable iff (rst)
      accept |=> out.rd_addr == $past(exp_addr) && out.wr_addr == $past(exp_addr))
      else begin
         err_count++;
         $error("[ERROR] %0t: linear address %0h, expected %0h",
                $time, out.rd_addr, $past(exp_addr));
      end

   a_attr: assert property (@(posedge CLK) disable iff (rst)
      accept |=> out.rd == $past(uop_in.rd) && out.wr == $past(uop_in.wr)
                 && out.size == $past(uop_in.size))
      else begin
         err_count++;
         $error("[ERROR] %0t: rd, wr or size not carried to the output", $time);
      end

   a_exc: assert property (@(posedge CLK) disable iff (rst)
      accept |=> out.seg_limit_exc == $past(exp_exc))
      else begin
         err_count++;
         $error("[ERROR] %0t: seg_limit_exc is %0b", $time, out.seg_limit_exc);
      end

   a_stall: assert property (@(posedge CLK) disable iff (rst)
      stall |=> $stable(out))
      else begin
         err_count++;
         $error("[ERROR] %0t: out changed during stall", $time);
      end

   a_reset: assert property (@(posedge CLK) disable iff (rst)
      !seen_valid |-> !out.valid && !out.seg_limit_exc)
      else begin
         err_count++;
         $error("[ERROR] %0t: out active before first valid uop", $time);
      end

endmodule

bind agen_top agen_assertions u_agen_assertions (
   .CLK     (CLK),
   .rst     (rst),
   .psel    (psel),
   .penable (penable),
   .pwrite  (pwrite),
   .paddr   (paddr),
   .pwdata  (pwdata),
   .prdata  (prdata),
   .pready  (pready),
   .pslverr (pslverr),
   .uop_in  (uop_in),
   .stall   (stall),
   .out     (out)
);

// File: sim/agen_tb.sv
`include "agen_consts.svh"

module agen_tb
   import agen_pkg::*;
();

   localparam int          APB_TIMEOUT   = 16;
   localparam int          DRAIN_TIMEOUT = 16;
   localparam logic [31:0] LFSR_POLY     = 32'h8020_0003;

   logic        CLK;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   agen_uop_t   uop_in;
   logic        stall;
   agen_out_t   out;

   logic [31:0] lfsr_state;
   logic [31:0] limit_wr [`AGEN_NUM_SEGS];
   int          tests_run;
   int          timeout_count;
   int unsigned errs_before;

   clk_gen u_clk_gen (.CLK (CLK));

   agen_top DUT (
      .CLK     (CLK),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .uop_in  (uop_in),
      .stall   (stall),
      .out     (out)
   );

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      logic        b;
      val = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr_state[0];
         lfsr_state = (lfsr_state >> 1) ^ (b ? LFSR_POLY : 32'd0);
         val = {val[30:0], b};
      end
      return val;
   endfunction

   function automatic logic [1:0] rand_size();
      logic [31:0] r;
      r = take_bits(2);
      return (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
   endfunction

   function automatic agen_uop_t mem_uop(input logic [2:0] seg, input logic [31:0] disp);
      agen_uop_t   u;
      logic [31:0] r;
      u = '0;
      u.valid = 1'b1;
      u.kind = kind_mem;
      u.seg = seg;
      u.size = rand_size();
      r = take_bits(1);
      u.rd = !r[0];
      u.wr = r[0];
      u.payload.mem.disp = disp;
      return u;
   endfunction

   task automatic apply_reset();
      rst    <= 1'b1;
      uop_in <= '0;
      stall  <= 1'b0;
      repeat (5) @(posedge CLK);
      rst <= 1'b0;
   endtask

   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
      int n;
      @(posedge CLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge CLK);
      penable <= 1'b1;
      n = 0;
      do begin
         @(posedge CLK);
         n++;
      end while (!pready && n < APB_TIMEOUT);
      if (!pready) begin
         timeout_count++;
         $display("APB transfer at address %0h never completed", addr);
      end
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic send_uop(input agen_uop_t u, input logic stl);
      @(posedge CLK);
      uop_in <= u;
      stall  <= stl;
   endtask

   task automatic drain_pipe();
      int n;
      @(posedge CLK);
      uop_in.valid <= 1'b0;
      stall        <= 1'b0;
      n = 0;
      do begin
         @(negedge CLK);
         n++;
      end while (out.valid && n < DRAIN_TIMEOUT);
      if (out.valid) begin
         timeout_count++;
         $display("Pipeline output never went idle");
      end
   endtask

   // Two start operands, then steady steps on one segment
   task automatic string_run(input logic df, input int stall_at);
      agen_uop_t   u;
      logic [31:0] r;
      logic [1:0]  sz;
      logic [2:0]  seg;
      sz = rand_size();
      r = take_bits(3);
      seg = r[2:0];
      for (int k = 0; k < 10; k++) begin
         r = take_bits(30);
         u = '0;
         u.valid = 1'b1;
         u.kind = kind_str;
         u.seg = seg;
         u.size = sz;
         u.df = df;
         u.rd = 1'b1;
         u.payload.str.ptr = r[29:0];
         u.payload.str.second = k[0];
         u.payload.str.steady = (k >= 2);
         send_uop(u, 1'b0);
         if (k == stall_at)
            repeat (3) send_uop(u, 1'b1);
      end
      drain_pipe();
   endtask

   task automatic finish_test(input string name);
      int unsigned errs;
      errs = DUT.u_agen_assertions.err_count;
      tests_run++;
      $display("%s: %0d assertion errors", name, errs - errs_before);
      errs_before = errs;
   endtask

   initial begin
      agen_uop_t   u;
      logic [31:0] r;
      logic [31:0] ofs;
      int unsigned errs;

      lfsr_state    = 32'd39;
      tests_run     = 0;
      timeout_count = 0;
      errs_before   = 0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      uop_in  = '0;
      stall   = 1'b0;
      apply_reset();

      // Top segment gets the full range so wrapping accesses are reached
      for (int i = 0; i < `AGEN_NUM_SEGS; i++) begin
         limit_wr[i] = (i == `AGEN_NUM_SEGS - 1) ? 32'hFFFF_FFFF
                                                : (take_bits(20) | 32'h0000_1000);
         apb_xfer(1'b1, 8'(i * `AGEN_APB_STRIDE), take_bits(32));
         apb_xfer(1'b1, 8'(i * `AGEN_APB_STRIDE + 4), limit_wr[i]);
      end
      for (int i = 0; i < 2 * `AGEN_NUM_SEGS; i++)
         apb_xfer(1'b0, 8'(i * 4), 32'd0);
      apb_xfer(1'b0, 8'h02, 32'd0);
      apb_xfer(1'b0, 8'h40, 32'd0);
      apb_xfer(1'b1, 8'hF8, 32'hDEAD_BEEF);
      finish_test("apb access");

      repeat (24) begin
         r = take_bits(3);
         u = mem_uop(r[2:0], take_bits(32));
         send_uop(u, 1'b0);
      end
      drain_pipe();
      finish_test("memory form");

      for (int s = 0; s < `AGEN_NUM_SEGS; s++) begin
         repeat (4) begin
            r = take_bits(3);
            ofs = limit_wr[s] - 32'd4 + r;
            u = mem_uop(3'(s), ofs);
            send_uop(u, 1'b0);
         end
      end
      // Last bytes spill past the top of the full-range segment
      u = mem_uop(3'(`AGEN_NUM_SEGS - 1), 32'hFFFF_FFFE);
      u.size = 2'd2;
      send_uop(u, 1'b0);
      drain_pipe();
      finish_test("segment limit");

      string_run(1'b0, -1);
      string_run(1'b1, -1);
      finish_test("string compare");

      string_run(1'b0, 1);
      string_run(1'b1, 5);
      finish_test("stall");

      // Reset lands while an exception result sits in the output latch
      u = mem_uop(3'd0, 32'hFFFF_FF00);
      send_uop(u, 1'b0);
      @(posedge CLK);
      apply_reset();
      repeat (4) begin
         r = take_bits(3);
         u = mem_uop(r[2:0], take_bits(32));
         u.valid = 1'b0;
         send_uop(u, 1'b0);
      end
      send_uop(u, 1'b1);
      u = mem_uop(3'd0, take_bits(32));
      send_uop(u, 1'b0);
      drain_pipe();
      finish_test("reset");

      errs = DUT.u_agen_assertions.err_count;
      $display("tests %0d, assertion errors %0d, timeouts %0d",
               tests_run, errs, timeout_count);
      if (errs == 0 && timeout_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: sim/clk_gen.sv
module clk_gen (
   output logic CLK
);

   initial CLK = 1'b0;

   // Period of 4
   always #2 CLK = ~CLK;

endmodule

// File: verilog/agen_consts.svh
`ifndef AGEN_CONSTS_SVH
`define AGEN_CONSTS_SVH

// Eight segment registers, selected by a 3-bit id
`define AGEN_NUM_SEGS 8
`define AGEN_SEG_ID_W 3

// Linear and effective address width
`define AGEN_ADDR_W 32

// APB map: base word then limit word per segment
`define AGEN_APB_ADDR_W 8
`define AGEN_APB_STRIDE 8
`define AGEN_APB_BASE_OFS 3'd0
`define AGEN_APB_LIMIT_OFS 3'd4
`define AGEN_APB_MAP_BYTES (`AGEN_NUM_SEGS * `AGEN_APB_STRIDE)

`endif

// File: verilog/agen_pkg.sv
`include "agen_consts.svh"

package agen_pkg;

   typedef struct packed {
      logic [`AGEN_ADDR_W-1:0] base;
      logic [`AGEN_ADDR_W-1:0] limit;
   } seg_desc_t;

   // Memory form, plain displacement
   typedef struct packed {
      logic [31:0] disp;
   } mem_form_t;

   // String form, start pointer plus phase bits
   typedef struct packed {
      logic [29:0] ptr;
      logic        second;
      logic        steady;
   } str_form_t;

   typedef union packed {
      mem_form_t mem;
      str_form_t str;
   } uop_payload_u;

   typedef enum logic {
      kind_mem = 1'b0,
      kind_str = 1'b1
   } uop_kind_e;

   typedef struct packed {
      logic                     valid;
      uop_kind_e                kind;
      logic [`AGEN_SEG_ID_W-1:0] seg;
      logic [1:0]               size;
      logic                     df;
      logic                     rd;
      logic                     wr;
      uop_payload_u             payload;
   } agen_uop_t;

   typedef struct packed {
      logic                    valid;
      logic [`AGEN_ADDR_W-1:0] rd_addr;
      logic [`AGEN_ADDR_W-1:0] wr_addr;
      logic                    rd;
      logic                    wr;
      logic [1:0]              size;
      logic                    seg_limit_exc;
   } agen_out_t;

endpackage

// File: verilog/agen_stage.sv
`include "agen_consts.svh"

module agen_stage
   import agen_pkg::*;
(
   input  logic                      CLK,
   input  logic                      rst,
   input  logic                      stall,
   input  agen_uop_t                 uop_in,
   output logic [`AGEN_SEG_ID_W-1:0] seg_id,
   input  seg_desc_t                 desc,
   output agen_out_t                 out
);

   logic                    is_str;
   logic                    adv;
   logic [31:0]             str_ptr;
   logic [31:0]             offset;
   logic [`AGEN_ADDR_W-1:0] lin_addr;
   logic                    limit_exc;
   agen_out_t               out_d;

   assign seg_id = uop_in.seg;
   assign is_str = uop_in.kind == kind_str;

   // Pointers only move on accepted string uops
   assign adv = uop_in.valid && is_str && !stall;

   string_ptr_tracker u_string_ptr_tracker (
      .CLK (CLK),
      .rst (rst),
      .adv (adv),
      .uop (uop_in),
      .ptr (str_ptr)
   );

   // Payload decode by kind
   assign offset = is_str ? str_ptr : uop_in.payload.mem.disp;

   assign lin_addr = desc.base + offset;

   seg_limit_check u_seg_limit_check (
      .offset (offset),
      .size   (uop_in.size),
      .limit  (desc.limit),
      .exc    (limit_exc)
   );

   always_comb begin
      out_d               = '0;
      out_d.valid         = uop_in.valid;
      out_d.rd_addr       = lin_addr;
      out_d.wr_addr       = lin_addr;
      out_d.rd            = uop_in.rd;
      out_d.wr            = uop_in.wr;
      out_d.size          = uop_in.size;
      out_d.seg_limit_exc = uop_in.valid && limit_exc;
   end

   // Pipeline latch, held on stall
   always_ff @(posedge CLK) begin
      if (rst) begin
         out.valid         <= 1'b0;
         out.seg_limit_exc <= 1'b0;
      end else if (!stall) begin
         out <= out_d;
      end
   end

endmodule

// File: verilog/agen_top.sv
`include "agen_consts.svh"

module agen_top
   import agen_pkg::*;
(
   input  logic                        CLK,
   input  logic                        rst,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [`AGEN_APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   input  agen_uop_t                   uop_in,
   input  logic                        stall,
   output agen_out_t                   out
);

   logic [`AGEN_SEG_ID_W-1:0] seg_id;
   seg_desc_t                 desc;

   seg_desc_table u_seg_desc_table (
      .CLK     (CLK),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .seg_id  (seg_id),
      .desc    (desc)
   );

   agen_stage u_agen_stage (
      .CLK    (CLK),
      .rst    (rst),
      .stall  (stall),
      .uop_in (uop_in),
      .seg_id (seg_id),
      .desc   (desc),
      .out    (out)
   );

endmodule

// File: verilog/seg_desc_table.sv
`include "agen_consts.svh"

module seg_desc_table
   import agen_pkg::*;
(
   input  logic                        CLK,
   input  logic                        rst,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [`AGEN_APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   input  logic [`AGEN_SEG_ID_W-1:0]   seg_id,
   output seg_desc_t                   desc
);

   seg_desc_t                 desc_q [`AGEN_NUM_SEGS];
   logic                      in_map;
   logic [`AGEN_SEG_ID_W-1:0] reg_seg;
   logic [2:0]                reg_ofs;
   logic [31:0]               rd_word;
   logic                      wr_en;

   assign in_map  = paddr < `AGEN_APB_MAP_BYTES;
   assign reg_seg = paddr[`AGEN_SEG_ID_W+2:3];
   assign reg_ofs = paddr[2:0];
   assign wr_en   = psel && penable && pwrite && in_map;

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = psel && penable && !in_map;

   always_comb begin
      rd_word = '0;
      if (in_map) begin
         if (reg_ofs == `AGEN_APB_BASE_OFS)
            rd_word = desc_q[reg_seg].base;
         else if (reg_ofs == `AGEN_APB_LIMIT_OFS)
            rd_word = desc_q[reg_seg].limit;
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `AGEN_NUM_SEGS; i++)
            desc_q[i] <= '0;
         prdata <= '0;
      end else begin
         // Capture in setup so data is there for the access cycle
         if (psel && !penable && !pwrite)
            prdata <= rd_word;
         if (wr_en) begin
            if (reg_ofs == `AGEN_APB_BASE_OFS)
               desc_q[reg_seg].base <= pwdata;
            if (reg_ofs == `AGEN_APB_LIMIT_OFS)
               desc_q[reg_seg].limit <= pwdata;
         end
      end
   end

   // Stage lookup
   assign desc = desc_q[seg_id];

endmodule

// File: verilog/seg_limit_check.sv
module seg_limit_check (
   input  logic [31:0] offset,
   input  logic [1:0]  size,
   input  logic [31:0] limit,
   output logic        exc
);

   logic [32:0] bytes;
   logic [32:0] last_byte;
   logic        wrap;

   assign bytes = 33'd1 << size;

   // Carry kept in bit 32
   assign last_byte = {1'b0, offset} + bytes - 33'd1;
   assign wrap      = last_byte[32];

   // Past the limit or off the top of the address space
   assign exc = wrap || (last_byte[31:0] > limit);

endmodule

// File: verilog/string_ptr_tracker.sv
module string_ptr_tracker
   import agen_pkg::*;
(
   input  logic        CLK,
   input  logic        rst,
   input  logic        adv,
   input  agen_uop_t   uop,
   output logic [31:0] ptr
);

   logic [31:0] src_q;
   logic [31:0] dst_q;
   logic [31:0] bytes;
   logic [31:0] step;
   logic [31:0] start_ptr;
   logic [31:0] src_next;
   logic [31:0] dst_next;
   str_form_t   str;

   assign str = uop.payload.str;

   // 1, 2 or 4 bytes
   assign bytes = 32'd1 << uop.size;

   // DF set walks down
   assign step = uop.df ? (~bytes + 32'd1) : bytes;

   assign start_ptr = {2'b00, str.ptr};
   assign src_next  = src_q + step;
   assign dst_next  = dst_q + step;

   always_comb begin
      if (!str.steady)
         ptr = start_ptr;
      else if (str.second)
         ptr = dst_next;
      else
         ptr = src_next;
   end

   // First operand owns the source pointer, second the destination
   always_ff @(posedge CLK) begin
      if (rst) begin
         src_q <= '0;
         dst_q <= '0;
      end else if (adv) begin
         if (str.second)
            dst_q <= ptr;
         else
            src_q <= ptr;
      end
   end

endmodule
